/* logic/peripheral_pkg.sv */
package peripheral_pkg;

    // Chip side is one byte wide, processor side one word
    typedef logic [7:0]  Byte_t;
    typedef logic [31:0] Word_t;

    // Byte lanes in a processor word
    localparam int BUS_LANES = 4;

    // Word offset 0x4 selects the data register
    localparam int USB_A0_BIT = 2;

    // Cycles with chip select and strobe held low
    localparam int USB_WAIT_CYCLE = 4;

    // Stalled recovery cycles after the strobe rises
    localparam int USB_HOLD_CYCLE = 4;

    localparam int USB_MAX_CYCLE =
        (USB_WAIT_CYCLE > USB_HOLD_CYCLE) ? USB_WAIT_CYCLE : USB_HOLD_CYCLE;

    localparam int TIMER_WIDTH = $clog2(USB_MAX_CYCLE + 1);

    // Sequencer states
    typedef enum logic [1:0] {
        IDLE,
        STROBE,
        HOLD
    } usb_state_t;

    // Access kind recorded at acceptance
    typedef enum logic {
        ACC_READ,
        ACC_WRITE
    } usb_access_t;

endpackage

/* logic/usb_pin_if.sv */
`timescale 1ns/1ps

// Pin-side control from the access sequencer to the data port
interface usb_pin_if;

    logic load;      // Request accepted, latch a0 and write byte
    logic drive_en;  // Write access in progress
    logic capture;   // Last strobe cycle of a read

    modport seq (
        output load,
        output drive_en,
        output capture
    );

    modport port (
        input load,
        input drive_en,
        input capture
    );

endinterface

/* logic/usb_wait_timer.sv */
`timescale 1ns/1ps

module usb_wait_timer import peripheral_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic hold,
    output logic done
);

    logic [TIMER_WIDTH-1:0] count;
    logic [TIMER_WIDTH-1:0] load_value;
    logic                   busy;

    // Count runs down to zero, so load one less than the phase length
    assign load_value = hold ? TIMER_WIDTH'(USB_HOLD_CYCLE - 1)
                             : TIMER_WIDTH'(USB_WAIT_CYCLE - 1);

    assign done = busy && (count == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy  <= 1'b1;          // Restart also covers back-to-back phases
            count <= load_value;
        end else if (done) begin
            busy <= 1'b0;
        end else if (busy) begin
            count <= count - 1'b1;
        end
    end

endmodule

/* logic/usb_data_port.sv */
`timescale 1ns/1ps

module usb_data_port import peripheral_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    input  Word_t       bus_data_addr,
    input  Word_t       bus_data_write,

    usb_pin_if.port     pins,

    output logic        sl811_a0,
    inout  wire Byte_t  sl811_d,
    output Word_t       bus_data_read
);

    Byte_t wr_byte;

    // Only one pin-side byte is ever live
    always_ff @(posedge clk) begin
        if (pins.load) begin
            wr_byte <= bus_data_write[7:0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sl811_a0      <= 1'b0;
            bus_data_read <= '0;
        end else begin
            if (pins.load) begin
                sl811_a0 <= bus_data_addr[USB_A0_BIT];  // Low selects address register
            end
            if (pins.capture) begin
                bus_data_read <= {BUS_LANES{sl811_d}};  // Same byte in every lane
            end
        end
    end

    // Released to the chip outside write accesses
    assign sl811_d = pins.drive_en ? wr_byte : 'z;

endmodule

/* logic/usb_access_fsm.sv */
`timescale 1ns/1ps

module usb_access_fsm import peripheral_pkg::*; (
    input  logic   clk,
    input  logic   rst,

    input  logic   read_op,
    input  logic   write_op,

    usb_pin_if.seq pins,

    output logic   timer_start,
    output logic   timer_hold,
    input  logic   timer_done,

    output logic   sl811_cs_n,
    output logic   sl811_rd_n,
    output logic   sl811_wr_n,
    output logic   bus_stall
);

    usb_state_t  state;
    usb_access_t access;

    logic accept;
    logic strobe_end;
    logic hold_end;

    // Requests only count while idle, read takes priority
    assign accept     = (state == IDLE) && (read_op || write_op);
    assign strobe_end = (state == STROBE) && timer_done;
    assign hold_end   = (state == HOLD) && timer_done;

    assign pins.load    = accept;
    assign pins.capture = strobe_end && (access == ACC_READ);

    // Strobe phase starts at acceptance, hold phase right after it
    assign timer_start = accept || strobe_end;
    assign timer_hold  = (state == STROBE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= IDLE;
            access        <= ACC_READ;
            sl811_cs_n    <= 1'b1;
            sl811_rd_n    <= 1'b1;
            sl811_wr_n    <= 1'b1;
            bus_stall     <= 1'b0;
            pins.drive_en <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state      <= STROBE;
                        sl811_cs_n <= 1'b0;
                        bus_stall  <= 1'b1;
                        if (read_op) begin
                            access        <= ACC_READ;
                            sl811_rd_n    <= 1'b0;
                            pins.drive_en <= 1'b0;
                        end else begin
                            access        <= ACC_WRITE;
                            sl811_wr_n    <= 1'b0;
                            pins.drive_en <= 1'b1;  // Pins driven from here
                        end
                    end
                end

                STROBE: begin
                    if (strobe_end) begin
                        state      <= HOLD;
                        sl811_cs_n <= 1'b1;
                        sl811_rd_n <= 1'b1;
                        sl811_wr_n <= 1'b1;
                    end
                end

                HOLD: begin
                    // Data pins recover before the next access
                    if (hold_end) begin
                        state         <= IDLE;
                        bus_stall     <= 1'b0;
                        pins.drive_en <= 1'b0;
                    end
                end

                default: begin
                    state         <= IDLE;
                    sl811_cs_n    <= 1'b1;
                    sl811_rd_n    <= 1'b1;
                    sl811_wr_n    <= 1'b1;
                    bus_stall     <= 1'b0;
                    pins.drive_en <= 1'b0;
                end
            endcase
        end
    end

endmodule

/* logic/usb_controller.sv */
`timescale 1ns/1ps

module usb_controller import peripheral_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    input  logic        read_op,
    input  logic        write_op,

    input  Word_t       bus_data_addr,
    input  Word_t       bus_data_write,
    output Word_t       bus_data_read,
    output logic        bus_stall,
    output logic        usb_interrupt,

    output logic        sl811_a0,
    inout  wire Byte_t  sl811_d,
    output logic        sl811_wr_n,
    output logic        sl811_rd_n,
    output logic        sl811_cs_n,
    input  logic        sl811_intrq
);

    logic timer_start;
    logic timer_hold;
    logic timer_done;

    usb_pin_if pins ();

    assign usb_interrupt = sl811_intrq;  // No synchronizer, straight to the core

    usb_access_fsm u_fsm (
        .clk         (clk),
        .rst         (rst),
        .read_op     (read_op),
        .write_op    (write_op),
        .pins        (pins.seq),
        .timer_start (timer_start),
        .timer_hold  (timer_hold),
        .timer_done  (timer_done),
        .sl811_cs_n  (sl811_cs_n),
        .sl811_rd_n  (sl811_rd_n),
        .sl811_wr_n  (sl811_wr_n),
        .bus_stall   (bus_stall)
    );

    usb_wait_timer u_timer (
        .clk   (clk),
        .rst   (rst),
        .start (timer_start),
        .hold  (timer_hold),
        .done  (timer_done)
    );

    usb_data_port u_port (
        .clk            (clk),
        .rst            (rst),
        .bus_data_addr  (bus_data_addr),
        .bus_data_write (bus_data_write),
        .pins           (pins.port),
        .sl811_a0       (sl811_a0),
        .sl811_d        (sl811_d),
        .bus_data_read  (bus_data_read)
    );

endmodule

/* testbench/sl811_model.sv */
`timescale 1ns/1ps

// Register-level model of the SL811 parallel interface
module sl811_model import peripheral_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       a0,
    inout  wire Byte_t d,
    input  logic       cs_n,
    input  logic       rd_n,
    input  logic       wr_n
);

    localparam int REG_COUNT = 256;

    Byte_t addr_reg;
    Byte_t regs [REG_COUNT];
    Byte_t read_byte;
    logic  write_strobe;
    logic  read_strobe;

    assign write_strobe = !cs_n && !wr_n;
    assign read_strobe  = !cs_n && !rd_n;

    // a0 low reads back the address register
    assign read_byte = a0 ? regs[addr_reg] : addr_reg;

    assign d = read_strobe ? read_byte : 'z;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr_reg <= '0;
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= Byte_t'(i) ^ 8'hA5;  // Power-up fill
            end
        end else if (write_strobe) begin
            // Strobe spans several cycles, same byte each time
            if (a0) begin
                regs[addr_reg] <= d;
            end else begin
                addr_reg <= d;
            end
        end
    end

endmodule

/* testbench/usb_controller_checker.sv */
`timescale 1ns/1ps

module usb_controller_checker import peripheral_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  bus_stall,
    input logic  sl811_cs_n,
    input logic  sl811_rd_n,
    input logic  sl811_wr_n,
    input logic  drive_en,
    input logic  usb_interrupt,
    input logic  sl811_intrq,
    input Word_t bus_data_read
);

    // Idle outputs once reset has been seen
    reset_idle: assert property (@(posedge clk)
        rst |=> sl811_cs_n && sl811_rd_n && sl811_wr_n && !bus_stall && !drive_en
                && (bus_data_read == '0))
        else $error("outputs not idle after reset");

    strobe_length: assert property (@(posedge clk) disable iff (rst)
        $fell(sl811_cs_n) |-> ##(USB_WAIT_CYCLE - 1) !sl811_cs_n ##1 sl811_cs_n)
        else $error("chip select low for the wrong number of cycles");

    // Active read or write strobe, whichever one is low
    strobe_active_length: assert property (@(posedge clk) disable iff (rst)
        $fell(sl811_rd_n && sl811_wr_n) |->
            ##(USB_WAIT_CYCLE - 1) !(sl811_rd_n && sl811_wr_n)
            ##1 (sl811_rd_n && sl811_wr_n))
        else $error("read or write strobe low for the wrong number of cycles");

    // Exactly one strobe goes low with chip select
    strobe_select: assert property (@(posedge clk) disable iff (rst)
        $fell(sl811_cs_n) |-> (sl811_rd_n != sl811_wr_n))
        else $error("no single read or write strobe at chip select");

    strobe_inside_cs: assert property (@(posedge clk) disable iff (rst)
        sl811_cs_n |-> sl811_rd_n && sl811_wr_n)
        else $error("strobe active without chip select");

    no_double_strobe: assert property (@(posedge clk) disable iff (rst)
        !(!sl811_rd_n && !sl811_wr_n))
        else $error("read and write strobes low together");

    stall_with_cs: assert property (@(posedge clk) disable iff (rst)
        $rose(bus_stall) |-> $fell(sl811_cs_n))
        else $error("stall did not start with chip select");

    stall_length: assert property (@(posedge clk) disable iff (rst)
        $rose(bus_stall) |->
            ##(USB_WAIT_CYCLE + USB_HOLD_CYCLE - 1) bus_stall ##1 !bus_stall)
        else $error("stall held for the wrong number of cycles");

    // Pins driven only inside a write access
    drive_in_write: assert property (@(posedge clk) disable iff (rst)
        drive_en |-> bus_stall && sl811_rd_n)
        else $error("data pins driven outside a write access");

    drive_starts_write: assert property (@(posedge clk) disable iff (rst)
        $rose(drive_en) |-> !sl811_wr_n)
        else $error("data pin drive started without a write strobe");

    write_driven: assert property (@(posedge clk) disable iff (rst)
        !sl811_wr_n |-> drive_en)
        else $error("write strobe low while data pins are released");

    interrupt_pass: assert property (@(posedge clk)
        usb_interrupt == sl811_intrq)
        else $error("interrupt output does not follow the chip interrupt");

endmodule

bind usb_controller usb_controller_checker chk (
    .clk           (clk),
    .rst           (rst),
    .bus_stall     (bus_stall),
    .sl811_cs_n    (sl811_cs_n),
    .sl811_rd_n    (sl811_rd_n),
    .sl811_wr_n    (sl811_wr_n),
    .drive_en      (pins.drive_en),
    .usb_interrupt (usb_interrupt),
    .sl811_intrq   (sl811_intrq),
    .bus_data_read (bus_data_read)
);

/* testbench/usb_controller_tb.sv */
`timescale 1ns/1ps

module usb_controller_tb import peripheral_pkg::*; ();

    localparam int    CLK_HALF      = 50;
    localparam int    RESET_CYCLES  = 8;
    localparam int    RANDOM_SEED   = 20017;
    localparam int    STALL_TIMEOUT = 40;
    localparam int    NUM_TRANSFERS = 24;
    localparam int    NUM_REREADS   = 12;
    localparam Word_t ADDR_OFFSET   = 32'h0;
    localparam Word_t DATA_OFFSET   = 32'h4;

    logic       clk = 1'b0;
    logic       rst;
    logic       read_op;
    logic       write_op;
    Word_t      bus_data_addr;
    Word_t      bus_data_write;
    Word_t      bus_data_read;
    logic       bus_stall;
    logic       usb_interrupt;
    logic       sl811_a0;
    wire  [7:0] sl811_d;
    logic       sl811_wr_n;
    logic       sl811_rd_n;
    logic       sl811_cs_n;
    logic       sl811_intrq;

    Byte_t shadow_regs [256];  // Expected chip register contents
    Byte_t written_addrs [$];

    always #CLK_HALF clk = ~clk;

    usb_controller UUT (
        .clk            (clk),
        .rst            (rst),
        .read_op        (read_op),
        .write_op       (write_op),
        .bus_data_addr  (bus_data_addr),
        .bus_data_write (bus_data_write),
        .bus_data_read  (bus_data_read),
        .bus_stall      (bus_stall),
        .usb_interrupt  (usb_interrupt),
        .sl811_a0       (sl811_a0),
        .sl811_d        (sl811_d),
        .sl811_wr_n     (sl811_wr_n),
        .sl811_rd_n     (sl811_rd_n),
        .sl811_cs_n     (sl811_cs_n),
        .sl811_intrq    (sl811_intrq)
    );

    sl811_model chip (
        .clk  (clk),
        .rst  (rst),
        .a0   (sl811_a0),
        .d    (sl811_d),
        .cs_n (sl811_cs_n),
        .rd_n (sl811_rd_n),
        .wr_n (sl811_wr_n)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic compare_word(input string test_name, input Word_t expected,
                                input Word_t actual);
        assert (actual == expected)
            else stop_with_failure($sformatf("FAIL %s expected %h actual %h",
                                             test_name, expected, actual));
    endtask

    // Samples on the falling edge, away from the DUT's updates
    task automatic wait_stall_level(input logic level, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (bus_stall !== level) begin
            if (cycles == STALL_TIMEOUT) begin
                stop_with_failure($sformatf("Timed out waiting for bus_stall to go %0b in %s",
                                            level, what));
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic start_request(input logic is_read, input Word_t addr, input Word_t data);
        @(posedge clk);
        read_op        <= is_read;
        write_op       <= !is_read;
        bus_data_addr  <= addr;
        bus_data_write <= data;
        @(posedge clk);          // Accepted here
        read_op  <= 1'b0;
        write_op <= 1'b0;
        wait_stall_level(1'b1, "request acceptance");
    endtask

    task automatic bus_write(input Word_t addr, input Word_t data);
        start_request(1'b0, addr, data);
        wait_stall_level(1'b0, "write access");
    endtask

    task automatic bus_read(input Word_t addr, output Word_t data);
        start_request(1'b1, addr, '0);
        wait_stall_level(1'b0, "read access");
        data = bus_data_read;
    endtask

    // Pulses a write and then a read while the access is still stalled
    task automatic access_with_noise(input logic is_read, input Word_t addr,
                                     input Word_t data, input Word_t noise_addr,
                                     input Word_t noise_data, output Word_t rdata);
        start_request(is_read, addr, data);
        @(posedge clk);
        write_op       <= 1'b1;
        bus_data_addr  <= noise_addr;
        bus_data_write <= noise_data;
        @(posedge clk);
        write_op <= 1'b0;
        read_op  <= 1'b1;
        @(posedge clk);
        read_op <= 1'b0;
        wait_stall_level(1'b0, "access with ignored requests");
        rdata = bus_data_read;
    endtask

    // Interrupt line toggles at random for the pass-through assertion
    initial begin
        sl811_intrq = 1'b0;
        forever begin
            @(posedge clk);
            sl811_intrq <= 1'($urandom);
        end
    end

    initial begin
        Word_t       got;
        Byte_t       reg_addr;
        Byte_t       reg_value;
        int unsigned pick;

        void'($urandom(RANDOM_SEED));
        rst            = 1'b1;
        read_op        = 1'b0;
        write_op       = 1'b0;
        bus_data_addr  = '0;
        bus_data_write = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        assert (sl811_cs_n && sl811_rd_n && sl811_wr_n && !bus_stall)
            else stop_with_failure("Strobes, chip select or stall active after reset");
        compare_word("reset_read_data", 32'h0, bus_data_read);

        for (int i = 0; i < NUM_TRANSFERS; i++) begin
            reg_addr  = Byte_t'($urandom);
            reg_value = Byte_t'($urandom);
            // Upper bytes are don't care on the chip side
            bus_write(ADDR_OFFSET, {24'($urandom), reg_addr});
            bus_write(DATA_OFFSET, {24'($urandom), reg_value});
            shadow_regs[reg_addr] = reg_value;
            written_addrs.push_back(reg_addr);

            bus_read(DATA_OFFSET, got);
            compare_word("data_readback", {4{reg_value}}, got);
            bus_read(ADDR_OFFSET, got);
            compare_word("address_readback", {4{reg_addr}}, got);
        end

        // Earlier registers must still hold their bytes
        for (int i = 0; i < NUM_REREADS; i++) begin
            pick     = $urandom_range(0, written_addrs.size() - 1);
            reg_addr = written_addrs[pick];
            bus_write(ADDR_OFFSET, {24'h0, reg_addr});
            bus_read(DATA_OFFSET, got);
            compare_word("register_reread", {4{shadow_regs[reg_addr]}}, got);
        end

        reg_addr  = Byte_t'($urandom);
        reg_value = Byte_t'($urandom);
        bus_write(ADDR_OFFSET, {24'h0, reg_addr});
        access_with_noise(1'b0, DATA_OFFSET, {24'h0, reg_value},
                          ADDR_OFFSET, {24'h0, ~reg_addr}, got);
        shadow_regs[reg_addr] = reg_value;
        bus_read(ADDR_OFFSET, got);
        compare_word("ignored_address_write", {4{reg_addr}}, got);
        bus_read(DATA_OFFSET, got);
        compare_word("write_during_stall", {4{reg_value}}, got);

        access_with_noise(1'b1, DATA_OFFSET, '0,
                          DATA_OFFSET, {24'h0, ~reg_value}, got);
        compare_word("read_during_stall", {4{reg_value}}, got);
        bus_read(DATA_OFFSET, got);
        compare_word("ignored_data_write", {4{reg_value}}, got);

        $display(">>> PASS");
        $finish;
    end

endmodule

/* project.f */
logic/peripheral_pkg.sv
logic/usb_pin_if.sv
logic/usb_wait_timer.sv
logic/usb_data_port.sv
logic/usb_access_fsm.sv
logic/usb_controller.sv
testbench/sl811_model.sv
testbench/usb_controller_checker.sv
testbench/usb_controller_tb.sv

/* Makefile */
# Verilator build for the SL811 bridge testbench

VERILATOR ?= verilator
TOP       ?= usb_controller_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_TEXT ?= >>> PASS

SOURCES := $(wildcard logic/*.sv) $(wildcard testbench/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only when the pass line shows up in the simulation output
run: compile
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
